// File: source/spi_config.svh
/* Build-time sizes of the SPI register subsystem.
   Included by the packages and by every module that needs a width or a depth. */
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// bits per SPI frame, LSB first on the wire.
`define FRAME_BITS 32

// number of register addresses, the last one reads hw_status.
`define REG_COUNT 8

// flops in each SPI pin synchronizer.
`define SYNC_STAGES 2

`endif

// File: source/spi_frame_pkg.sv
/* Frame-level types shared by the SPI frame slave and the register bank.
   Import it wherever a frame, a byte of one or its fields are handled. */
`default_nettype none
`include "spi_config.svh"

package spi_frame_pkg;

   typedef logic [`FRAME_BITS-1:0] spi_word_t;   // one frame as a plain vector.
   typedef logic [7:0]             spi_byte_t;
   typedef logic [15:0]            spi_half_t;   // writable payload of a frame.

   // field order follows the wire, opcode is shifted first.
   typedef struct packed {
      spi_byte_t reserved;   // ignored on receive, zero on reply.
      spi_half_t data16;
      spi_byte_t opcode;     // carries the status byte on reply.
   } frame_fields_t;

   typedef struct packed {
      frame_fields_t fields;
      logic          overrun;   // the frame before this one was dropped.
   } rx_frame_t;

endpackage

`default_nettype wire

// File: source/reg_cmd_pkg.sv
/* Command-level types of the register bank.
   Opcode decoding, register values and the reply status byte all come from here. */
`default_nettype none
`include "spi_config.svh"

package reg_cmd_pkg;

   // coded in opcode bits 7-6.
   typedef enum logic [1:0] {
      CMD_NOP     = 2'b00,
      CMD_READ    = 2'b01,
      CMD_WRITE   = 2'b10,
      CMD_ILLEGAL = 2'b11
   } reg_cmd_e;

   typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;   // opcode bits 2-0.
   typedef logic [15:0]                   reg_data_t;

   // laid out like the opcode byte so the master reads the echo in place.
   typedef struct packed {
      reg_cmd_e  cmd;
      logic      error;     // illegal command or write to the status address.
      logic      overrun;
      logic      spare;     // always zero.
      reg_addr_t addr;
   } reply_status_t;

endpackage

`default_nettype wire

// File: source/spi_frame_slave.sv
/* SPI mode 0 frame slave. Oversamples the pins in the clk domain, hands each
   finished frame to the register bank and shifts the loaded reply out on MISO. */
`timescale 1ns/1ps
`default_nettype none
`include "spi_config.svh"

module spi_frame_slave
   import spi_frame_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          sck,
   input  logic          ss_n,
   input  logic          mosi,
   output logic          miso,
   output rx_frame_t     rx_frame,
   output logic          rx_valid,
   input  logic          rx_ready,
   input  frame_fields_t reply,
   input  logic          reply_valid,
   output logic          reply_ready
);

   localparam int CNT_W = $clog2(`FRAME_BITS);
   localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`FRAME_BITS - 1);

   logic [`SYNC_STAGES-1:0] sck_sync;
   logic [`SYNC_STAGES-1:0] ss_sync;
   logic [`SYNC_STAGES-1:0] mosi_sync;
   logic                    sck_prev;
   logic                    ss_prev;
   logic                    sck_s;
   logic                    ss_s;
   logic                    mosi_s;
   logic                    sck_rise;
   logic                    sck_fall;
   logic                    ss_edge;
   logic [CNT_W-1:0]        bit_cnt;
   spi_word_t               rx_shift;
   spi_word_t               tx_shift;
   logic                    overrun_pending;
   logic                    frame_done;
   logic                    frame_accept;
   logic                    rx_take;
   logic                    reply_load;

   assign sck_s  = sck_sync[`SYNC_STAGES-1];
   assign ss_s   = ss_sync[`SYNC_STAGES-1];
   assign mosi_s = mosi_sync[`SYNC_STAGES-1];

   assign sck_rise = sck_s & ~sck_prev;
   assign sck_fall = ~sck_s & sck_prev;
   assign ss_edge  = ss_s ^ ss_prev;

   assign frame_done   = sck_rise & ~ss_s & ~ss_edge & (bit_cnt == LAST_BIT);
   assign frame_accept = frame_done & (~rx_valid | rx_ready);   // else the frame is lost.
   assign rx_take      = rx_valid & rx_ready;

   assign reply_ready = ss_s;   // loads only between frames.
   assign reply_load  = reply_valid & reply_ready;
   assign miso        = tx_shift[0];

   always_ff @(posedge clk) begin
      if (reset) begin
         sck_sync  <= '0;
         ss_sync   <= '1;   // deselected.
         mosi_sync <= '0;
         sck_prev  <= 1'b0;
         ss_prev   <= 1'b1;
      end else begin
         sck_sync  <= {sck_sync[`SYNC_STAGES-2:0], sck};
         ss_sync   <= {ss_sync[`SYNC_STAGES-2:0], ss_n};
         mosi_sync <= {mosi_sync[`SYNC_STAGES-2:0], mosi};
         sck_prev  <= sck_s;
         ss_prev   <= ss_s;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt <= '0;
      end else if (ss_edge) begin
         bit_cnt <= '0;
      end else if (sck_rise && !ss_s) begin
         bit_cnt <= (bit_cnt == LAST_BIT) ? '0 : bit_cnt + 1'b1;
      end
   end

   // LSB first, so new bits enter at the top.
   always_ff @(posedge clk) begin
      if (sck_rise && !ss_s) begin
         rx_shift <= {mosi_s, rx_shift[`FRAME_BITS-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rx_valid        <= 1'b0;
         overrun_pending <= 1'b0;
      end else begin
         if (rx_take) begin
            rx_valid <= 1'b0;
         end
         if (frame_accept) begin
            rx_valid        <= 1'b1;
            overrun_pending <= 1'b0;
         end else if (frame_done) begin
            overrun_pending <= 1'b1;   // flagged on the next frame that gets through.
         end
      end
   end

   always_ff @(posedge clk) begin
      if (frame_accept) begin
         rx_frame.fields  <= frame_fields_t'({mosi_s, rx_shift[`FRAME_BITS-1:1]});
         rx_frame.overrun <= overrun_pending;
      end
   end

   // bit 0 sits on miso before the first rising edge.
   always_ff @(posedge clk) begin
      if (reset) begin
         tx_shift <= '0;
      end else if (reply_load) begin
         tx_shift <= spi_word_t'(reply);
      end else if (ss_s && !ss_prev) begin
         tx_shift <= '0;   // leftovers of a cut frame.
      end else if (sck_fall && !ss_s) begin
         tx_shift <= {1'b0, tx_shift[`FRAME_BITS-1:1]};
      end
   end

   a_rx_hold: assert property (@(posedge clk) disable iff (reset)
      rx_valid && !rx_ready |=> rx_valid && $stable(rx_frame));

   // a load lands only with the bus idle and no frame in progress.
   a_load_idle: assert property (@(posedge clk) disable iff (reset)
      reply_load |-> !sck_s && (bit_cnt == '0 || ss_edge));

endmodule

`default_nettype wire

// File: source/spi_reg_bank.sv
/* Register bank behind the SPI frame slave. Decodes each received frame,
   updates or reads a register and holds the reply until the slave takes it. */
`timescale 1ns/1ps
`default_nettype none
`include "spi_config.svh"

module spi_reg_bank
   import spi_frame_pkg::*;
   import reg_cmd_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  rx_frame_t     rx_frame,
   input  logic          rx_valid,
   output logic          rx_ready,
   output frame_fields_t reply,
   output logic          reply_valid,
   input  logic          reply_ready,
   input  reg_data_t     hw_status,
   output reg_data_t     ctrl_out
);

   localparam reg_addr_t STATUS_ADDR = reg_addr_t'(`REG_COUNT - 1);

   reg_data_t     regs [`REG_COUNT-1];   // the status address has no storage.
   reg_cmd_e      cmd;
   reg_addr_t     addr;
   reg_data_t     rd_data;
   reply_status_t status;
   logic          accept;
   logic          is_error;
   logic          wr_en;

   assign cmd  = reg_cmd_e'(rx_frame.fields.opcode[7:6]);
   assign addr = rx_frame.fields.opcode[$bits(reg_addr_t)-1:0];

   assign rx_ready = ~reply_valid;   // one-entry reply slot.
   assign accept   = rx_valid & rx_ready;

   assign is_error = (cmd == CMD_ILLEGAL) || (cmd == CMD_WRITE && addr == STATUS_ADDR);
   assign wr_en    = accept && cmd == CMD_WRITE && !is_error;

   assign ctrl_out = regs[0];

   always_comb begin
      rd_data = '0;
      if (cmd == CMD_READ) begin
         if (addr == STATUS_ADDR) begin
            rd_data = hw_status;
         end else begin
            rd_data = regs[addr];
         end
      end
   end

   always_comb begin
      status.cmd     = cmd;
      status.error   = is_error;
      status.overrun = rx_frame.overrun;
      status.spare   = 1'b0;
      status.addr    = addr;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `REG_COUNT - 1; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[addr] <= rx_frame.fields.data16;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         reply_valid <= 1'b0;
      end else if (accept) begin
         reply_valid <= 1'b1;
      end else if (reply_valid && reply_ready) begin
         reply_valid <= 1'b0;
      end
   end

   // the reply describes the frame just accepted.
   always_ff @(posedge clk) begin
      if (accept) begin
         reply.reserved <= '0;
         reply.data16   <= rd_data;
         reply.opcode   <= status;
      end
   end

   a_reply_hold: assert property (@(posedge clk) disable iff (reset)
      reply_valid && !reply_ready |=> reply_valid && $stable(reply));

endmodule

`default_nettype wire

// File: source/spi_reg_subsystem.sv
/* Top level of the SPI register subsystem.
   Connects the frame slave to the register bank through both handshakes. */
`timescale 1ns/1ps
`default_nettype none

module spi_reg_subsystem
   import spi_frame_pkg::*;
   import reg_cmd_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      sck,
   input  logic      ss_n,
   input  logic      mosi,
   output logic      miso,
   input  reg_data_t hw_status,
   output reg_data_t ctrl_out
);

   rx_frame_t     rx_frame;
   logic          rx_valid;
   logic          rx_ready;
   frame_fields_t reply;
   logic          reply_valid;
   logic          reply_ready;

   spi_frame_slave u_spi_frame_slave (
      .clk         (clk),
      .reset       (reset),
      .sck         (sck),
      .ss_n        (ss_n),
      .mosi        (mosi),
      .miso        (miso),
      .rx_frame    (rx_frame),
      .rx_valid    (rx_valid),
      .rx_ready    (rx_ready),
      .reply       (reply),
      .reply_valid (reply_valid),
      .reply_ready (reply_ready)
   );

   spi_reg_bank u_spi_reg_bank (
      .clk         (clk),
      .reset       (reset),
      .rx_frame    (rx_frame),
      .rx_valid    (rx_valid),
      .rx_ready    (rx_ready),
      .reply       (reply),
      .reply_valid (reply_valid),
      .reply_ready (reply_ready),
      .hw_status   (hw_status),
      .ctrl_out    (ctrl_out)
   );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
/* Free-running clock for the SPI register testbench, 40 ns period. */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int HALF_NS = 20
) (
   output logic clk
);

   initial clk = 1'b0;

   always #HALF_NS clk = ~clk;

endmodule

`default_nettype wire

// File: tb/spi_reg_subsystem_tb.sv
/* Testbench for the SPI register subsystem. Plays the frames of the trace file
   as an SPI mode 0 master and checks each reply and ctrl_out against the trace. */
`timescale 1ns/1ps
`default_nettype none

module spi_reg_subsystem_tb
   import spi_frame_pkg::*;
   import reg_cmd_pkg::*;
();

   localparam string TRACE_PATH  = "tb/spi_reg_trace.txt";
   localparam int    FRAME_BITS  = $bits(spi_word_t);
   localparam int    HALF_SCK    = 4;        // clk cycles per SCK half period.
   localparam int    RESET_CYCLES = 5;
   localparam int    RUN_LIMIT   = 100000;   // clk cycles before the run is abandoned.

   typedef struct packed {
      spi_word_t  frame;
      reg_data_t  hw;
      spi_word_t  reply;   // shifted out during the next frame.
      reg_data_t  ctrl;
      logic [7:0] gap;     // zero picks a random gap.
   } trace_entry_t;

   logic         clk;
   logic         reset;
   logic         sck;
   logic         ss_n;
   logic         mosi;
   logic         miso;
   reg_data_t    hw_status;
   reg_data_t    ctrl_out;

   trace_entry_t trace_q[$];
   logic [7:0]   lfsr_state;
   int           errors;
   int           checks;
   spi_word_t    captured;
   spi_word_t    expected_reply;
   int           gap_cycles;

   tb_clock_gen u_clock_gen (
      .clk (clk)
   );

   spi_reg_subsystem u_spi_reg_subsystem (
      .clk       (clk),
      .reset     (reset),
      .sck       (sck),
      .ss_n      (ss_n),
      .mosi      (mosi),
      .miso      (miso),
      .hw_status (hw_status),
      .ctrl_out  (ctrl_out)
   );

   // x^8 + x^6 + x^5 + x^4 + 1.
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      logic fb;
      fb = s[7] ^ s[5] ^ s[4] ^ s[3];
      return {s[6:0], fb};
   endfunction

   task automatic random_gap(output int g);
      g = 0;
      for (int k = 0; k < 3; k++) begin
         lfsr_state = lfsr_step(lfsr_state);   // one step per bit.
         g = (g << 1) | lfsr_state[0];
      end
      g = 8 + g;
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic wait_clocks(input int n);
      for (int k = 0; k < n; k++) begin
         @(posedge clk);
      end
   endtask

   task automatic load_trace();
      int        fd;
      int        n;
      string     line;
      spi_word_t frame;
      reg_data_t hw;
      spi_word_t reply;
      reg_data_t ctrl;
      int        gap;
      trace_entry_t entry;
      fd = $fopen(TRACE_PATH, "r");
      if (fd == 0) begin
         errors++;
         $display("the trace file %s could not be opened", TRACE_PATH);
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%h %h %h %h %d", frame, hw, reply, ctrl, gap);
               if (n == 5) begin
                  entry.frame = frame;
                  entry.hw    = hw;
                  entry.reply = reply;
                  entry.ctrl  = ctrl;
                  entry.gap   = gap[7:0];
                  trace_q.push_back(entry);
               end else if (n > 0) begin
                  errors++;
                  $display("a trace line has fewer than five fields: %s", line);
               end
            end
         end
         $fclose(fd);
      end
      if (trace_q.size() == 0) begin
         errors++;
         $display("no frames were read from the trace file");
      end
   endtask

   // mode 0 master that takes miso just before each SCK rising edge.
   task automatic send_frame(input spi_word_t tx, output spi_word_t rx);
      rx = '0;
      @(posedge clk);
      ss_n <= 1'b0;
      mosi <= tx[0];
      wait_clocks(HALF_SCK);
      for (int b = 0; b < FRAME_BITS; b++) begin
         @(negedge clk);
         rx[b] = miso;
         @(posedge clk);
         sck <= 1'b1;
         wait_clocks(HALF_SCK);
         sck <= 1'b0;
         if (b < FRAME_BITS - 1) begin
            mosi <= tx[b+1];
         end
         wait_clocks(HALF_SCK - 1);
      end
      wait_clocks(1);
      ss_n <= 1'b1;
   endtask

   initial begin
      for (int c = 0; c < RUN_LIMIT; c++) begin
         @(posedge clk);
      end
      $display("timeout: the run did not finish within %0d clock cycles", RUN_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      reset      <= 1'b1;
      sck        <= 1'b0;
      ss_n       <= 1'b1;
      mosi       <= 1'b0;
      hw_status  <= '0;
      lfsr_state = 8'd70;
      errors     = 0;
      checks     = 0;
      load_trace();
      wait_clocks(RESET_CYCLES);
      reset <= 1'b0;
      wait_clocks(10);
      expected_reply = '0;   // nothing loaded before the first frame.
      foreach (trace_q[i]) begin
         @(posedge clk);
         hw_status <= trace_q[i].hw;
         send_frame(trace_q[i].frame, captured);
         check_value($sformatf("reply during frame %0d", i), captured, expected_reply);
         expected_reply = trace_q[i].reply;
         if (trace_q[i].gap == 0) begin
            random_gap(gap_cycles);
         end else begin
            gap_cycles = trace_q[i].gap;
         end
         wait_clocks(gap_cycles);
         @(negedge clk);
         check_value($sformatf("ctrl_out after frame %0d", i), {16'h0, ctrl_out},
                     {16'h0, trace_q[i].ctrl});
      end
      send_frame('0, captured);   // flushes the last reply.
      check_value("reply during the closing frame", captured, expected_reply);
      wait_clocks(10);
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/spi_frame_pkg.sv
source/reg_cmd_pkg.sv
source/spi_frame_slave.sv
source/spi_reg_bank.sv
source/spi_reg_subsystem.sv
tb/tb_clock_gen.sv
tb/spi_reg_subsystem_tb.sv

// File: Bender.yml
package:
  name: spi_reg_subsystem

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/spi_frame_pkg.sv
      - source/reg_cmd_pkg.sv
      - source/spi_frame_slave.sv
      - source/spi_reg_bank.sv
      - source/spi_reg_subsystem.sv

  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/spi_reg_subsystem_tb.sv

// File: tb/spi_reg_trace.txt
# columns: frame, hw_status, reply expected on the next frame, ctrl_out after the frame, gap
# all hex except the gap, given in clk cycles with ss_n high; a gap of 0 picks 8 to 15 at random
00123480 0000 00000080 1234 0
00BEEF81 0000 00000081 1234 8
005A5A85 0000 00000085 1234 0
00000041 0000 00BEEF41 1234 0
00FFFF40 0000 00123440 1234 12
00000045 0000 005A5A45 1234 0
00000047 C3A5 00C3A547 1234 0
00000047 0F0F 000F0F47 1234 9
00DEAD87 0F0F 000000A7 1234 0
00000047 0F0F 000F0F47 1234 0
009999C0 0F0F 000000E0 1234 0
007777C1 0000 000000E1 1234 20
00000041 0000 00BEEF41 1234 0
00000040 0000 00123440 1234 0
00ABCD02 0000 00000002 1234 0
00000000 0000 00000000 1234 8
A500FF80 0000 00000080 00FF 0
0000FF80 0000 00000080 00FF 0
5C000040 0000 0000FF40 00FF 0
00000040 0000 0000FF40 00FF 10
FF000182 0000 00000082 00FF 0
00000042 0000 00000142 00FF 0
00000043 0000 00000043 00FF 0
00000046 0000 00000046 00FF 0
00000080 0000 00000080 0000 0
00000040 0000 00000040 0000 0
